// ==== src.f ====
+incdir+.
mul_sel_pkg.sv
req_fifo.sv
rsp_credit_ctrl.sv
wallace_mul_8x8.sv
mul_sel_pipe.sv
mul_sel_top.sv
mul_sel_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the mul/select testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module mul_sel_tb -f src.f -o mul_sel_sim \
    > build.log 2>&1 \
    && ./obj_dir/mul_sel_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
exit 0

// ==== mul_sel_tb.sv ====
// Mul/select unit testbench: table-driven requests with credit models on both sides
`include "mul_sel_cfg.svh"

module mul_sel_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mul_sel_pkg::*;

    localparam int N_CORNER    = 6;
    localparam int N_RAND      = 16;
    localparam int N_MIX       = 12;
    localparam int N_BP        = `MS_FIFO_DEPTH + `MS_OUT_CREDITS; // Fills credits and buffer
    localparam int N_ENTRIES   = N_CORNER + N_RAND + N_MIX + N_BP;
    localparam int CYCLE_LIMIT = 10 * N_ENTRIES + 200;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    logic                  req_op;
    logic                  req_sel;
    operand_word_u         req_word;
    logic                  rsp_credit;
    logic                  req_credit;
    logic                  rsp_valid;
    logic [`MS_WORD_W-1:0] rsp_data;

    // Stimulus table
    logic                  tab_op   [N_ENTRIES];
    logic                  tab_sel  [N_ENTRIES];
    operand_word_u         tab_word [N_ENTRIES];
    logic [`MS_WORD_W-1:0] tab_exp  [N_ENTRIES];
    int                    n_entries = 0;

    logic [`MS_WORD_W-1:0] exp_q [$];
    logic [31:0]           lfsr_state = 32'h1c62_51cc;

    int up_credits         = `MS_FIFO_DEPTH;
    int sent_count         = 0;
    int req_credit_count   = 0;
    int max_outstanding    = 0;
    int rsp_count          = 0;
    int pending_rsp_credit = 0;
    bit hold_credits       = 1'b0;
    int err_count          = 0;
    int pass_tests         = 0;
    int fail_tests         = 0;
    int cycle_count        = 0;

    mul_sel_top DUT (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_sel    (req_sel),
        .req_word   (req_word),
        .rsp_credit (rsp_credit),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], next_lfsr_bit()};
        end
        return v;
    endfunction

    function automatic void add_mul(input logic [7:0] a, input logic [7:0] b);
        tab_op[n_entries]                = 1'b1;
        tab_sel[n_entries]               = a[0]; // Ignored by a multiply
        tab_word[n_entries].mul.factor_a = a;
        tab_word[n_entries].mul.factor_b = b;
        tab_exp[n_entries]               = 16'(a) * 16'(b);
        n_entries++;
    endfunction

    function automatic void add_sel(input logic sel, input logic [7:0] d1, input logic [7:0] d0);
        tab_op[n_entries]             = 1'b0;
        tab_sel[n_entries]            = sel;
        tab_word[n_entries].sel.data1 = d1;
        tab_word[n_entries].sel.data0 = d0;
        tab_exp[n_entries]            = {8'h00, sel ? d1 : d0};
        n_entries++;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
            pass_tests++;
        end else begin
            $display("test %s: %0d error(s)", name, err_count - errs_before);
            fail_tests++;
        end
    endtask

    // Called at posedge + 10 ns, returns at the same phase
    task automatic send_entry(input int idx);
        while (up_credits == 0) begin
            req_valid = 1'b0;
            @(posedge clk);
            #10;
        end
        req_valid = 1'b1;
        req_op    = tab_op[idx];
        req_sel   = tab_sel[idx];
        req_word  = tab_word[idx];
        exp_q.push_back(tab_exp[idx]);
        up_credits--;
        sent_count++;
        @(posedge clk);
        #10;
        req_valid = 1'b0;
    endtask

    task automatic send_range(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            send_entry(i);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || pending_rsp_credit != 0
               || req_credit_count != sent_count) begin
            @(posedge clk);
            #10;
        end
        repeat (2) begin // Last returned credit reaches the DUT
            @(posedge clk);
            #10;
        end
    endtask

    // Outputs are pulses, read mid-cycle
    always @(negedge clk) begin
        if (rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived with no request outstanding");
                err_count++;
            end else begin
                check_value("rsp_data", rsp_data, exp_q.pop_front());
            end
            rsp_count++;
            pending_rsp_credit++;
        end
        if (req_credit) begin
            up_credits++;
            req_credit_count++;
        end
        if (sent_count - req_credit_count > max_outstanding)
            max_outstanding = sent_count - req_credit_count;
    end

    // Downstream returns one credit per consumed response
    initial begin
        rsp_credit = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (!hold_credits && pending_rsp_credit > 0) begin
                rsp_credit = 1'b1;
                pending_rsp_credit--;
            end else begin
                rsp_credit = 1'b0;
            end
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [7:0] a;
        logic [7:0] b;
        int         errs;
        int         rsp_before;

        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = 1'b0;
        req_sel   = 1'b0;
        req_word  = '0;

        add_mul(8'h00, 8'hb7);
        add_mul(8'h01, 8'hc3);
        add_mul(8'hff, 8'hff);
        add_mul(8'h80, 8'h02);
        add_mul(8'hff, 8'h00);
        add_mul(8'h01, 8'hff);
        for (int i = 0; i < N_RAND; i++) begin
            a = random_byte();
            b = random_byte();
            add_mul(a, b);
        end
        for (int i = 0; i < N_MIX; i++) begin
            a = random_byte();
            b = random_byte();
            if (i % 3 == 2) add_mul(a, b);
            else add_sel(i % 3 == 1, a, b);
        end
        for (int i = 0; i < N_BP; i++) begin
            a = random_byte();
            b = random_byte();
            if (i % 2 == 0) add_mul(a, b);
            else add_sel(a[3], a, b);
        end

        errs = err_count;
        req_valid = 1'b1; // Must be dropped while reset is high
        repeat (5) begin
            @(posedge clk);
            #10;
            check_value("rsp_valid", rsp_valid, 0);
            check_value("req_credit", req_credit, 0);
        end
        reset     = 1'b0;
        req_valid = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #10;
            check_value("rsp_valid", rsp_valid, 0);
            check_value("req_credit", req_credit, 0);
        end
        report_test("reset state", errs);

        errs = err_count;
        send_range(0, N_CORNER + N_RAND);
        wait_drain();
        report_test("multiply table", errs);

        errs = err_count;
        send_range(N_CORNER + N_RAND, N_MIX);
        wait_drain();
        report_test("select mixed with multiply", errs);

        errs = err_count;
        rsp_before   = rsp_count;
        hold_credits = 1'b1;
        send_range(N_CORNER + N_RAND + N_MIX, N_BP);
        repeat (10) begin
            @(posedge clk);
            #10;
        end
        check_value("rsp_in_hold", rsp_count - rsp_before, `MS_OUT_CREDITS);
        hold_credits = 1'b0;
        wait_drain();
        check_value("rsp_after_release", rsp_count - rsp_before, N_BP);
        report_test("response back-pressure", errs);

        errs = err_count;
        check_value("req_credit_total", req_credit_count, sent_count);
        check_value("up_credits", up_credits, `MS_FIFO_DEPTH);
        // A full buffer under back-pressure holds exactly its depth
        if (max_outstanding != `MS_FIFO_DEPTH) begin
            $display("Upstream peaked at %0d outstanding requests, not the buffer depth %0d",
                     max_outstanding, `MS_FIFO_DEPTH);
            err_count++;
        end
        report_test("request credits", errs);

        $display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d responses",
                 pass_tests + fail_tests, pass_tests, fail_tests, err_count, rsp_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== mul_sel_top.sv ====
// Mul/select unit top: request buffer, response credits and datapath
`include "mul_sel_cfg.svh"

module mul_sel_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    input  logic                       req_op,    // 1 multiply, 0 select
    input  logic                       req_sel,
    input  mul_sel_pkg::operand_word_u req_word,
    input  logic                       rsp_credit,
    output logic                       req_credit,
    output logic                       rsp_valid,
    output logic [`MS_WORD_W-1:0]      rsp_data
);
    import mul_sel_pkg::*;

    logic          not_empty;
    logic          issue;
    logic          head_op;
    logic          head_sel;
    operand_word_u head_word;

    req_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (req_valid),
        .push_op    (req_op),
        .push_sel   (req_sel),
        .push_word  (req_word),
        .pop        (issue),
        .not_empty  (not_empty),
        .head_op    (head_op),
        .head_sel   (head_sel),
        .head_word  (head_word),
        .req_credit (req_credit)
    );

    rsp_credit_ctrl u_credit (
        .clk        (clk),
        .reset      (reset),
        .not_empty  (not_empty),
        .rsp_credit (rsp_credit),
        .issue      (issue)
    );

    // Issue pops the head straight into the datapath
    mul_sel_pipe u_pipe (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (issue),
        .in_op     (head_op),
        .in_sel    (head_sel),
        .in_word   (head_word),
        .out_valid (rsp_valid),
        .out_data  (rsp_data)
    );

endmodule

// ==== mul_sel_pipe.sv ====
// Mul/select datapath: byte select or multiply, both results aligned to two stages
`include "mul_sel_cfg.svh"

module mul_sel_pipe (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  logic                       in_op,
    input  logic                       in_sel,
    input  mul_sel_pkg::operand_word_u in_word,
    output logic                       out_valid,
    output logic [`MS_WORD_W-1:0]      out_data
);

    localparam int unsigned BW = `MS_BYTE_W;
    localparam int unsigned WW = `MS_WORD_W;

    logic [WW-1:0] product;
    logic [BW-1:0] sel_byte;

    wallace_mul_8x8 u_mul (
        .clk     (clk),
        .reset   (reset),
        .a       (in_word.mul.factor_a),
        .b       (in_word.mul.factor_b),
        .product (product)
    );

    assign sel_byte = in_sel ? in_word.sel.data1 : in_word.sel.data0;

    logic          valid_q1, valid_q2;
    logic          op_q1, op_q2;
    logic [BW-1:0] byte_q1, byte_q2;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            valid_q1 <= in_valid;
            valid_q2 <= valid_q1;
        end
    end

    // Same depth as the multiplier so results stay in order
    always_ff @(posedge clk) begin
        op_q1   <= in_op;
        byte_q1 <= sel_byte;
        op_q2   <= op_q1;
        byte_q2 <= byte_q1;
    end

    assign out_valid = valid_q2;
    assign out_data  = op_q2 ? product : {{(WW - BW){1'b0}}, byte_q2};

endmodule

// ==== wallace_mul_8x8.sv ====
// Unsigned 8x8 Wallace-tree multiplier, carry-save rows then final add, two stages
`include "mul_sel_cfg.svh"

module wallace_mul_8x8 (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MS_BYTE_W-1:0] a,
    input  logic [`MS_BYTE_W-1:0] b,
    output logic [`MS_WORD_W-1:0] product
);

    localparam int unsigned BW = `MS_BYTE_W;
    localparam int unsigned WW = `MS_WORD_W;

    // Row of full adders, sum part
    function automatic logic [WW-1:0] fa_sum(
        input logic [WW-1:0] x,
        input logic [WW-1:0] y,
        input logic [WW-1:0] z
    );
        return x ^ y ^ z;
    endfunction

    // Row of full adders, carry moved up one column
    function automatic logic [WW-1:0] fa_carry(
        input logic [WW-1:0] x,
        input logic [WW-1:0] y,
        input logic [WW-1:0] z
    );
        logic [WW-1:0] maj;
        maj = (x & y) | (x & z) | (y & z);
        return {maj[WW-2:0], 1'b0};
    endfunction

    logic [WW-1:0] pp [BW];

    // Partial products, each shifted to its column
    always_comb begin
        for (int i = 0; i < BW; i++) begin
            pp[i] = {{(WW - BW){1'b0}}, a & {BW{b[i]}}} << i;
        end
    end

    // Layer 1: 8 rows to 6
    logic [WW-1:0] s1_0, c1_0, s1_1, c1_1;
    assign s1_0 = fa_sum(pp[0], pp[1], pp[2]);
    assign c1_0 = fa_carry(pp[0], pp[1], pp[2]);
    assign s1_1 = fa_sum(pp[3], pp[4], pp[5]);
    assign c1_1 = fa_carry(pp[3], pp[4], pp[5]);

    // Layer 2: 6 rows to 4
    logic [WW-1:0] s2_0, c2_0, s2_1, c2_1;
    assign s2_0 = fa_sum(s1_0, c1_0, s1_1);
    assign c2_0 = fa_carry(s1_0, c1_0, s1_1);
    assign s2_1 = fa_sum(c1_1, pp[6], pp[7]);
    assign c2_1 = fa_carry(c1_1, pp[6], pp[7]);

    // Layer 3: 4 rows to 3
    logic [WW-1:0] s3_0, c3_0;
    assign s3_0 = fa_sum(s2_0, c2_0, s2_1);
    assign c3_0 = fa_carry(s2_0, c2_0, s2_1);

    // Layer 4: last two rows
    logic [WW-1:0] sum_row, carry_row;
    assign sum_row   = fa_sum(s3_0, c3_0, c2_1);
    assign carry_row = fa_carry(s3_0, c3_0, c2_1);

    logic [WW-1:0] sum_q;
    logic [WW-1:0] carry_q;

    // Stage 1 holds the reduced rows
    always_ff @(posedge clk) begin
        if (reset) begin
            sum_q   <= '0;
            carry_q <= '0;
        end else begin
            sum_q   <= sum_row;
            carry_q <= carry_row;
        end
    end

    // Stage 2 carry-propagate add
    always_ff @(posedge clk) begin
        if (reset) begin
            product <= '0;
        end else begin
            product <= sum_q + carry_q;
        end
    end

endmodule

// ==== rsp_credit_ctrl.sv ====
// Response credit control: counts downstream credits and issues buffered work
`include "mul_sel_cfg.svh"

module rsp_credit_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic not_empty,
    input  logic rsp_credit,
    output logic issue
);

    localparam int unsigned CREDITS = `MS_OUT_CREDITS;
    localparam int unsigned CNT_W   = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;

    // Credit taken at issue, so every in-flight item owns a response slot
    assign issue = not_empty && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else begin
            case ({issue, rsp_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt; // Both or neither
            endcase
        end
    end

endmodule

// ==== req_fifo.sv ====
// Request buffer: circular store of op, sel and word, credit pulse per pop
`include "mul_sel_cfg.svh"

module req_fifo (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        push,
    input  logic                        push_op,
    input  logic                        push_sel,
    input  mul_sel_pkg::operand_word_u  push_word,
    input  logic                        pop,
    output logic                        not_empty,
    output logic                        head_op,
    output logic                        head_sel,
    output mul_sel_pkg::operand_word_u  head_word,
    output logic                        req_credit
);
    import mul_sel_pkg::*;

    localparam int unsigned DEPTH = `MS_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic          op_mem   [DEPTH];
    logic          sel_mem  [DEPTH];
    operand_word_u word_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]   <= push_op;
            sel_mem[wr_ptr]  <= push_sel;
            word_mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            req_credit <= pop; // One freed entry, one credit back
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign not_empty = (count != '0);
    assign head_op   = op_mem[rd_ptr];
    assign head_sel  = sel_mem[rd_ptr];
    assign head_word = word_mem[rd_ptr];

endmodule

// ==== mul_sel_pkg.sv ====
// Mul/select package: operand word decoded as two factors or two data bytes
`include "mul_sel_cfg.svh"

package mul_sel_pkg;

    // Same 16 bits, two readings chosen by the request's op bit
    typedef union packed {
        struct packed {
            logic [`MS_BYTE_W-1:0] factor_a; // High byte
            logic [`MS_BYTE_W-1:0] factor_b;
        } mul;
        struct packed {
            logic [`MS_BYTE_W-1:0] data1;    // Chosen when sel is 1
            logic [`MS_BYTE_W-1:0] data0;
        } sel;
    } operand_word_u;

endpackage

// ==== mul_sel_cfg.svh ====
// Mul/select unit configuration: buffer depth, response credits and data widths
`ifndef MUL_SEL_CFG_SVH
`define MUL_SEL_CFG_SVH

// Request buffer entries, also upstream's starting credit
`define MS_FIFO_DEPTH  4

// Response credits held after reset
`define MS_OUT_CREDITS 4

`define MS_BYTE_W      8
`define MS_WORD_W      16

`endif
